// File: hdl/conv2d_cfg_pkg.sv
package conv2d_cfg_pkg;

    localparam int DWIDTH = 32;
    localparam int AWIDTH = 10;

    // kernel edge and its zero padding
    localparam int WT_DIM    = 3;
    localparam int HALO_CNT  = WT_DIM - 1;
    localparam int HALF_HALO = HALO_CNT / 2;

    localparam int FM_MAX_DIM = 16;

    // write fifo must take a whole FM_MAX_DIM x FM_MAX_DIM result map
    localparam int RD_FIFO_LOGDEPTH = 4;
    localparam int PE_FIFO_LOGDEPTH = 6;
    localparam int WR_FIFO_LOGDEPTH = 8;

    localparam int MEM_WORDS = 1024;

    typedef logic [DWIDTH-1:0] word_t;
    typedef logic [AWIDTH-1:0] addr_t;

endpackage

// File: hdl/conv2d_ctrl_pkg.sv
package conv2d_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_WT,
        LOAD_FM,
        LAST_WRITE,
        STORE_FM
    } compute_state_e;

    // burst length in words
    typedef logic [15:0] len_t;

endpackage

// File: hdl/conv2d_fifo.sv
`timescale 1ns/1ps

module conv2d_fifo #(
    parameter int WIDTH    = conv2d_cfg_pkg::DWIDTH,
    parameter int LOGDEPTH = conv2d_cfg_pkg::RD_FIFO_LOGDEPTH
) (
    input  logic             clk,
    input  logic             write_counter_rst,
    input  logic             enq_valid,
    input  logic [WIDTH-1:0] enq_data,
    output logic             enq_ready,
    output logic             deq_valid,
    output logic [WIDTH-1:0] deq_data,
    input  logic             deq_ready
);

    logic [WIDTH-1:0]    mem [1 << LOGDEPTH];
    logic [LOGDEPTH-1:0] rd_ptr;
    logic [LOGDEPTH-1:0] wr_ptr;
    logic [LOGDEPTH:0]   count;
    logic                enq_fire;
    logic                deq_fire;

    // count tops out at the depth, so its msb is the full flag
    assign enq_ready = ~count[LOGDEPTH];
    assign deq_valid = (count != '0);
    assign deq_data  = mem[rd_ptr];
    assign enq_fire  = enq_valid & enq_ready;
    assign deq_fire  = deq_valid & deq_ready;

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            mem[wr_ptr] <= enq_data;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (enq_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (enq_fire && !deq_fire) begin
                count <= count + 1'b1;
            end else if (deq_fire && !enq_fire) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hdl/conv2d_pe.sv
`timescale 1ns/1ps

module conv2d_pe #(
    parameter int ROW = 0
) (
    input  logic                                      clk,
    input  logic                                      write_counter_rst,
    input  conv2d_ctrl_pkg::len_t                     fm_dim,
    input  logic                                      weight_valid,
    input  logic [$clog2(conv2d_cfg_pkg::WT_DIM)-1:0] weight_row_sel,
    input  conv2d_cfg_pkg::word_t                     weight_data,
    input  logic                                      sample_valid,
    input  conv2d_cfg_pkg::word_t                     sample_data,
    output logic                                      pe_valid,
    output conv2d_cfg_pkg::word_t                     pe_data
);

    import conv2d_cfg_pkg::*;
    import conv2d_ctrl_pkg::*;

    word_t weight [WT_DIM];
    word_t window [WT_DIM];
    word_t window_nxt [WT_DIM];
    word_t dot;
    len_t  x_cnt;
    len_t  y_cnt;
    len_t  grid_last;
    logic  row_active;

    assign grid_last  = fm_dim + len_t'(HALO_CNT - 1);
    // padded rows this kernel row touches
    assign row_active = (y_cnt >= len_t'(ROW)) && (y_cnt < fm_dim + len_t'(ROW));

    // window after the incoming sample, oldest entry at index 0
    always_comb begin
        for (int k = 0; k < WT_DIM - 1; k++) begin
            window_nxt[k] = window[k+1];
        end
        window_nxt[WT_DIM-1] = sample_data;
        dot = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            dot = dot + weight[k] * window_nxt[k];
        end
    end

    always_ff @(posedge clk) begin
        if (weight_valid && int'(weight_row_sel) == ROW) begin
            for (int k = 0; k < WT_DIM - 1; k++) begin
                weight[k] <= weight[k+1];
            end
            weight[WT_DIM-1] <= weight_data;
        end
        if (sample_valid) begin
            window  <= window_nxt;
            pe_data <= dot;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            pe_valid <= 1'b0;
            x_cnt    <= '0;
            y_cnt    <= '0;
        end else begin
            pe_valid <= sample_valid && (x_cnt >= len_t'(HALO_CNT)) && row_active;
            if (sample_valid) begin
                if (x_cnt == grid_last) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == grid_last) ? '0 : y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: hdl/conv2d_compute.sv
`timescale 1ns/1ps

module conv2d_compute (
    input  logic                   clk,
    input  logic                   write_counter_rst,
    input  logic                   start,
    output logic                   idle,
    input  conv2d_ctrl_pkg::len_t  fm_dim,
    input  conv2d_cfg_pkg::addr_t  wt_offset,
    input  conv2d_cfg_pkg::addr_t  ifm_offset,
    input  conv2d_cfg_pkg::addr_t  ofm_offset,
    output conv2d_cfg_pkg::addr_t  req_read_addr,
    output conv2d_ctrl_pkg::len_t  req_read_len,
    output logic                   req_read_addr_valid,
    input  logic                   req_read_addr_ready,
    input  conv2d_cfg_pkg::word_t  rdata,
    input  logic                   rdata_valid,
    output logic                   rdata_ready,
    output conv2d_cfg_pkg::addr_t  req_write_addr,
    output conv2d_ctrl_pkg::len_t  req_write_len,
    output logic                   req_write_addr_valid,
    input  logic                   req_write_addr_ready,
    output conv2d_cfg_pkg::word_t  req_write_data,
    output logic                   req_write_data_valid,
    input  logic                   req_write_data_ready,
    input  logic                   resp_write_status,
    input  logic                   resp_write_status_valid,
    output logic                   resp_write_status_ready
);

    import conv2d_cfg_pkg::*;
    import conv2d_ctrl_pkg::*;

    compute_state_e            state_q;
    compute_state_e            state_d;
    logic [$clog2(WT_DIM)-1:0] m_cnt;
    logic [$clog2(WT_DIM)-1:0] n_cnt;
    len_t                      x_cnt;
    len_t                      y_cnt;
    len_t                      wr_cnt;
    len_t                      fm_words;
    len_t                      grid_last;
    len_t                      halo_hi;
    logic                      rd_deq_valid;
    logic                      rd_deq_ready;
    logic                      rd_fire;
    word_t                     rd_deq_data;
    logic                      halo;
    logic                      step;
    logic                      wt_last;
    word_t                     sample_data;
    logic [WT_DIM-1:0]         pe_valid;
    word_t                     pe_data [WT_DIM];
    logic [WT_DIM-1:0]         pe_deq_valid;
    word_t                     pe_deq_data [WT_DIM];
    logic                      pe_fire;
    word_t                     pe_sum;
    logic                      wr_enq_ready;
    logic                      wr_deq_valid;

    assign idle      = (state_q == IDLE);
    assign fm_words  = fm_dim * fm_dim;
    assign grid_last = fm_dim + len_t'(HALO_CNT - 1);
    assign halo_hi   = fm_dim + len_t'(HALF_HALO);

    // read bursts: weights, then the feature map
    assign req_read_addr = (state_q == LOAD_FM) ? ifm_offset : wt_offset;
    assign req_read_len  = (state_q == LOAD_FM) ? fm_words : len_t'(WT_DIM * WT_DIM);

    conv2d_fifo #(.WIDTH(DWIDTH), .LOGDEPTH(RD_FIFO_LOGDEPTH)) u_rd_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (rdata_valid),
        .enq_data          (rdata),
        .enq_ready         (rdata_ready),
        .deq_valid         (rd_deq_valid),
        .deq_data          (rd_deq_data),
        .deq_ready         (rd_deq_ready)
    );

    assign halo = (x_cnt < len_t'(HALF_HALO)) || (y_cnt < len_t'(HALF_HALO))
                  || (x_cnt >= halo_hi) || (y_cnt >= halo_hi);
    // halo positions take no read data
    assign rd_deq_ready = (state_q == LOAD_WT) || (state_q == LOAD_FM && !halo);
    assign rd_fire      = rd_deq_valid & rd_deq_ready;
    assign step         = (state_q == LOAD_FM) && (halo || rd_fire);
    assign sample_data  = halo ? '0 : rd_deq_data;
    assign wt_last      = rd_fire && (state_q == LOAD_WT)
                          && int'(m_cnt) == WT_DIM - 1 && int'(n_cnt) == WT_DIM - 1;

    for (genvar i = 0; i < WT_DIM; i++) begin : g_row
        conv2d_pe #(.ROW(i)) u_pe (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .fm_dim            (fm_dim),
            .weight_valid      (state_q == LOAD_WT && rd_fire),
            .weight_row_sel    (m_cnt),
            .weight_data       (rd_deq_data),
            .sample_valid      (step),
            .sample_data       (sample_data),
            .pe_valid          (pe_valid[i]),
            .pe_data           (pe_data[i])
        );

        // depth covers the row lag between kernel rows
        conv2d_fifo #(.WIDTH(DWIDTH), .LOGDEPTH(PE_FIFO_LOGDEPTH)) u_pe_fifo (
            .clk               (clk),
            .write_counter_rst (write_counter_rst),
            .enq_valid         (pe_valid[i]),
            .enq_data          (pe_data[i]),
            .enq_ready         (),
            .deq_valid         (pe_deq_valid[i]),
            .deq_data          (pe_deq_data[i]),
            .deq_ready         (pe_fire)
        );
    end

    always_comb begin
        pe_sum = '0;
        for (int k = 0; k < WT_DIM; k++) begin
            pe_sum = pe_sum + pe_deq_data[k];
        end
    end

    assign pe_fire = (&pe_deq_valid) & wr_enq_ready;

    conv2d_fifo #(.WIDTH(DWIDTH), .LOGDEPTH(WR_FIFO_LOGDEPTH)) u_wr_fifo (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .enq_valid         (&pe_deq_valid),
        .enq_data          (pe_sum),
        .enq_ready         (wr_enq_ready),
        .deq_valid         (wr_deq_valid),
        .deq_data          (req_write_data),
        .deq_ready         (req_write_data_ready && state_q == STORE_FM)
    );

    assign req_write_data_valid    = wr_deq_valid && (state_q == STORE_FM);
    assign req_write_addr          = ofm_offset;
    assign req_write_len           = fm_words;
    assign resp_write_status_ready = (state_q == STORE_FM);

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (start) state_d = LOAD_WT;
            LOAD_WT:    if (wt_last) state_d = LOAD_FM;
            LOAD_FM:    if (step && x_cnt == grid_last && y_cnt == grid_last) state_d = LAST_WRITE;
            LAST_WRITE: if (wr_cnt == fm_words) state_d = STORE_FM;
            STORE_FM:   if (resp_write_status_valid) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            state_q              <= IDLE;
            m_cnt                <= '0;
            n_cnt                <= '0;
            x_cnt                <= '0;
            y_cnt                <= '0;
            wr_cnt               <= '0;
            req_read_addr_valid  <= 1'b0;
            req_write_addr_valid <= 1'b0;
        end else begin
            state_q <= state_d;
            // one-shot read request on entry to LOAD_WT and LOAD_FM
            if ((idle && start) || wt_last) begin
                req_read_addr_valid <= 1'b1;
            end else if (req_read_addr_ready) begin
                req_read_addr_valid <= 1'b0;
            end
            if (state_q == LAST_WRITE && state_d == STORE_FM) begin
                req_write_addr_valid <= 1'b1;
            end else if (req_write_addr_ready) begin
                req_write_addr_valid <= 1'b0;
            end
            if (state_q == LOAD_WT && rd_fire) begin
                n_cnt <= (int'(n_cnt) == WT_DIM - 1) ? '0 : n_cnt + 1'b1;
                if (int'(n_cnt) == WT_DIM - 1) begin
                    m_cnt <= (int'(m_cnt) == WT_DIM - 1) ? '0 : m_cnt + 1'b1;
                end
            end
            if (step) begin
                if (x_cnt == grid_last) begin
                    x_cnt <= '0;
                    y_cnt <= (y_cnt == grid_last) ? '0 : y_cnt + 1'b1;
                end else begin
                    x_cnt <= x_cnt + 1'b1;
                end
            end
            if (idle && start) begin
                wr_cnt <= '0;
            end else if (pe_fire) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/conv2d_io_mem.sv
`timescale 1ns/1ps

module conv2d_io_mem (
    input  logic                   clk,
    input  logic                   write_counter_rst,
    input  logic                   host_we,
    input  conv2d_cfg_pkg::addr_t  host_addr,
    input  conv2d_cfg_pkg::word_t  host_wdata,
    output conv2d_cfg_pkg::word_t  host_rdata,
    input  conv2d_cfg_pkg::addr_t  req_read_addr,
    input  conv2d_ctrl_pkg::len_t  req_read_len,
    input  logic                   req_read_addr_valid,
    output logic                   req_read_addr_ready,
    output conv2d_cfg_pkg::word_t  rdata,
    output logic                   rdata_valid,
    input  logic                   rdata_ready,
    input  conv2d_cfg_pkg::addr_t  req_write_addr,
    input  conv2d_ctrl_pkg::len_t  req_write_len,
    input  logic                   req_write_addr_valid,
    output logic                   req_write_addr_ready,
    input  conv2d_cfg_pkg::word_t  req_write_data,
    input  logic                   req_write_data_valid,
    output logic                   req_write_data_ready,
    output logic                   resp_write_status,
    output logic                   resp_write_status_valid,
    input  logic                   resp_write_status_ready
);

    import conv2d_cfg_pkg::*;
    import conv2d_ctrl_pkg::*;

    word_t mem [MEM_WORDS];
    addr_t rd_addr;
    addr_t wr_addr;
    len_t  rd_left;
    len_t  wr_left;
    logic  rd_accept;
    logic  rd_fire;
    logic  wr_accept;
    logic  wr_fire;

    assign req_read_addr_ready = (rd_left == '0);
    assign rd_accept           = req_read_addr_valid & req_read_addr_ready;
    assign rdata_valid         = (rd_left != '0);
    assign rdata               = mem[rd_addr];
    assign rd_fire             = rdata_valid & rdata_ready;

    // next write burst waits until the response is taken
    assign req_write_addr_ready = (wr_left == '0) & ~resp_write_status_valid;
    assign wr_accept            = req_write_addr_valid & req_write_addr_ready;
    assign req_write_data_ready = (wr_left != '0);
    assign wr_fire              = req_write_data_valid & req_write_data_ready;

    always_ff @(posedge clk) begin
        // out-of-range bursts are consumed but not stored
        if (wr_fire && resp_write_status) begin
            mem[wr_addr] <= req_write_data;
        end
        if (host_we) begin
            mem[host_addr] <= host_wdata;
        end
        host_rdata <= mem[host_addr];
        if (rd_accept) begin
            rd_addr <= req_read_addr;
        end else if (rd_fire) begin
            rd_addr <= rd_addr + 1'b1;
        end
        if (wr_accept) begin
            wr_addr           <= req_write_addr;
            resp_write_status <= (int'(req_write_addr) + int'(req_write_len) <= MEM_WORDS);
        end else if (wr_fire) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_counter_rst) begin
            rd_left                 <= '0;
            wr_left                 <= '0;
            resp_write_status_valid <= 1'b0;
        end else begin
            if (rd_accept) begin
                rd_left <= req_read_len;
            end else if (rd_fire) begin
                rd_left <= rd_left - 1'b1;
            end
            if (wr_accept) begin
                wr_left <= req_write_len;
            end else if (wr_fire) begin
                wr_left <= wr_left - 1'b1;
            end
            if ((wr_accept && req_write_len == '0) || (wr_fire && wr_left == len_t'(1))) begin
                resp_write_status_valid <= 1'b1;
            end else if (resp_write_status_ready) begin
                resp_write_status_valid <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/conv2d_top.sv
`timescale 1ns/1ps

module conv2d_top (
    input  logic                   clk,
    input  logic                   write_counter_rst,
    input  logic                   start,
    output logic                   idle,
    input  conv2d_ctrl_pkg::len_t  fm_dim,
    input  conv2d_cfg_pkg::addr_t  wt_offset,
    input  conv2d_cfg_pkg::addr_t  ifm_offset,
    input  conv2d_cfg_pkg::addr_t  ofm_offset,
    input  logic                   host_we,
    input  conv2d_cfg_pkg::addr_t  host_addr,
    input  conv2d_cfg_pkg::word_t  host_wdata,
    output conv2d_cfg_pkg::word_t  host_rdata
);

    import conv2d_cfg_pkg::*;
    import conv2d_ctrl_pkg::*;

    addr_t req_read_addr;
    len_t  req_read_len;
    logic  req_read_addr_valid;
    logic  req_read_addr_ready;
    word_t rdata;
    logic  rdata_valid;
    logic  rdata_ready;
    addr_t req_write_addr;
    len_t  req_write_len;
    logic  req_write_addr_valid;
    logic  req_write_addr_ready;
    word_t req_write_data;
    logic  req_write_data_valid;
    logic  req_write_data_ready;
    logic  resp_write_status;
    logic  resp_write_status_valid;
    logic  resp_write_status_ready;

    conv2d_compute u_compute (
        .clk                     (clk),
        .write_counter_rst       (write_counter_rst),
        .start                   (start),
        .idle                    (idle),
        .fm_dim                  (fm_dim),
        .wt_offset               (wt_offset),
        .ifm_offset              (ifm_offset),
        .ofm_offset              (ofm_offset),
        .req_read_addr           (req_read_addr),
        .req_read_len            (req_read_len),
        .req_read_addr_valid     (req_read_addr_valid),
        .req_read_addr_ready     (req_read_addr_ready),
        .rdata                   (rdata),
        .rdata_valid             (rdata_valid),
        .rdata_ready             (rdata_ready),
        .req_write_addr          (req_write_addr),
        .req_write_len           (req_write_len),
        .req_write_addr_valid    (req_write_addr_valid),
        .req_write_addr_ready    (req_write_addr_ready),
        .req_write_data          (req_write_data),
        .req_write_data_valid    (req_write_data_valid),
        .req_write_data_ready    (req_write_data_ready),
        .resp_write_status       (resp_write_status),
        .resp_write_status_valid (resp_write_status_valid),
        .resp_write_status_ready (resp_write_status_ready)
    );

    conv2d_io_mem u_io_mem (
        .clk                     (clk),
        .write_counter_rst       (write_counter_rst),
        .host_we                 (host_we),
        .host_addr               (host_addr),
        .host_wdata              (host_wdata),
        .host_rdata              (host_rdata),
        .req_read_addr           (req_read_addr),
        .req_read_len            (req_read_len),
        .req_read_addr_valid     (req_read_addr_valid),
        .req_read_addr_ready     (req_read_addr_ready),
        .rdata                   (rdata),
        .rdata_valid             (rdata_valid),
        .rdata_ready             (rdata_ready),
        .req_write_addr          (req_write_addr),
        .req_write_len           (req_write_len),
        .req_write_addr_valid    (req_write_addr_valid),
        .req_write_addr_ready    (req_write_addr_ready),
        .req_write_data          (req_write_data),
        .req_write_data_valid    (req_write_data_valid),
        .req_write_data_ready    (req_write_data_ready),
        .resp_write_status       (resp_write_status),
        .resp_write_status_valid (resp_write_status_valid),
        .resp_write_status_ready (resp_write_status_ready)
    );

endmodule

// File: verification/conv2d_tb.sv
`timescale 1ns/1ps

module conv2d_tb;

    import conv2d_cfg_pkg::*;
    import conv2d_ctrl_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 2;
    localparam int NUM_RUNS       = 8;
    localparam int RUN_CYCLES     = 2000;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES;

    logic  clk;
    logic  write_counter_rst;
    logic  start;
    logic  idle;
    len_t  fm_dim;
    addr_t wt_offset;
    addr_t ifm_offset;
    addr_t ofm_offset;
    logic  host_we;
    addr_t host_addr;
    word_t host_wdata;
    word_t host_rdata;

    int    seed;
    int    cycle_cnt = 0;
    word_t w_ref [WT_DIM][WT_DIM];
    word_t fm_ref [FM_MAX_DIM][FM_MAX_DIM];

    conv2d_top DUT (
        .clk               (clk),
        .write_counter_rst (write_counter_rst),
        .start             (start),
        .idle              (idle),
        .fm_dim            (fm_dim),
        .wt_offset         (wt_offset),
        .ifm_offset        (ifm_offset),
        .ofm_offset        (ofm_offset),
        .host_we           (host_we),
        .host_addr         (host_addr),
        .host_wdata        (host_wdata),
        .host_rdata        (host_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h exp %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_idle(input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH idle got %h exp %h", got, exp);
            abort_run();
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic host_write(input int addr, input word_t data);
        host_we    = 1'b1;
        host_addr  = addr_t'(addr);
        host_wdata = data;
        step_cycle();
        host_we    = 1'b0;
    endtask

    // host_rdata follows host_addr by one cycle
    task automatic host_read(input int addr, output word_t data);
        host_addr = addr_t'(addr);
        step_cycle();
        data = host_rdata;
    endtask

    function automatic int random_dim();
        return 3 + int'($unsigned($random(seed)) % (FM_MAX_DIM - 2));
    endfunction

    function automatic word_t sentinel_word(input int addr);
        return 32'h5e17_0000 ^ word_t'(addr);
    endfunction

    // zero padded correlation, 32-bit wraparound
    function automatic word_t expected_out(input int dim, input int oy, input int ox);
        word_t acc;
        int    yy;
        int    xx;
        acc = '0;
        for (int r = 0; r < WT_DIM; r++) begin
            for (int c = 0; c < WT_DIM; c++) begin
                yy = oy + r - HALF_HALO;
                xx = ox + c - HALF_HALO;
                if (yy >= 0 && yy < dim && xx >= 0 && xx < dim) begin
                    acc = acc + w_ref[r][c] * fm_ref[yy][xx];
                end
            end
        end
        return acc;
    endfunction

    task automatic run_conv(input int dim, input int wt_off, input int ifm_off,
                            input int ofm_off, input bit ones_map, input bit extra_start);
        word_t got;
        int    lo_addr;
        int    hi_addr;
        lo_addr = ofm_off - 1;
        hi_addr = ofm_off + dim * dim;
        for (int r = 0; r < WT_DIM; r++) begin
            for (int c = 0; c < WT_DIM; c++) begin
                w_ref[r][c] = $random(seed);
                host_write(wt_off + r * WT_DIM + c, w_ref[r][c]);
            end
        end
        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                fm_ref[y][x] = ones_map ? word_t'(1) : word_t'($random(seed));
                host_write(ifm_off + y * dim + x, fm_ref[y][x]);
            end
        end
        // guard words around the output region
        host_write(lo_addr, sentinel_word(lo_addr));
        host_write(hi_addr, sentinel_word(hi_addr));

        fm_dim     = len_t'(dim);
        wt_offset  = addr_t'(wt_off);
        ifm_offset = addr_t'(ifm_off);
        ofm_offset = addr_t'(ofm_off);
        start      = 1'b1;
        step_cycle();
        start      = 1'b0;
        check_idle(idle, 1'b0);
        if (extra_start) begin
            repeat (20) step_cycle();
            check_idle(idle, 1'b0);
            start = 1'b1;
            step_cycle();
            start = 1'b0;
        end
        while (!idle) begin
            step_cycle();
        end
        // a finished run must not restart on its own
        repeat (3) begin
            step_cycle();
            check_idle(idle, 1'b1);
        end

        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                host_read(ofm_off + y * dim + x, got);
                check_word($sformatf("ofm[%0d][%0d]", y, x), got, expected_out(dim, y, x));
            end
        end
        host_read(lo_addr, got);
        check_word("sentinel_lo", got, sentinel_word(lo_addr));
        host_read(hi_addr, got);
        check_word("sentinel_hi", got, sentinel_word(hi_addr));
        for (int y = 0; y < dim; y++) begin
            for (int x = 0; x < dim; x++) begin
                host_read(ifm_off + y * dim + x, got);
                check_word($sformatf("ifm[%0d][%0d]", y, x), got, fm_ref[y][x]);
            end
        end
        for (int r = 0; r < WT_DIM; r++) begin
            for (int c = 0; c < WT_DIM; c++) begin
                host_read(wt_off + r * WT_DIM + c, got);
                check_word($sformatf("wt[%0d][%0d]", r, c), got, w_ref[r][c]);
            end
        end
    endtask

    initial begin
        word_t got;
        seed              = 95;
        write_counter_rst = 1'b1;
        start             = 1'b0;
        fm_dim            = len_t'(3);
        wt_offset         = '0;
        ifm_offset        = '0;
        ofm_offset        = '0;
        host_we           = 1'b0;
        host_addr         = '0;
        host_wdata        = '0;
        repeat (5) @(posedge clk);
        #(DRIVE_DELAY);
        write_counter_rst = 1'b0;
        check_idle(idle, 1'b1);

        host_write(1000, 32'h1234_abcd);
        host_read(1000, got);
        check_word("host_rdata", got, 32'h1234_abcd);

        // random maps, then halo checks at both edge sizes
        run_conv(random_dim(), 10, 40, 400, 1'b0, 1'b0);
        run_conv(random_dim(), 13, 45, 411, 1'b0, 1'b0);
        run_conv(3, 16, 50, 422, 1'b1, 1'b0);
        run_conv(FM_MAX_DIM, 19, 55, 433, 1'b1, 1'b0);
        run_conv(random_dim(), 22, 60, 444, 1'b0, 1'b0);
        run_conv(random_dim(), 25, 65, 455, 1'b0, 1'b0);
        // second start while busy
        run_conv(random_dim(), 28, 70, 466, 1'b0, 1'b1);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: files.f
hdl/conv2d_cfg_pkg.sv
hdl/conv2d_ctrl_pkg.sv
hdl/conv2d_fifo.sv
hdl/conv2d_pe.sv
hdl/conv2d_compute.sv
hdl/conv2d_io_mem.sv
hdl/conv2d_top.sv
verification/conv2d_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = conv2d_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
